/* mips_system.f */
mips_pkg.sv
mips_decode.sv
mips_alu.sv
mips_regfile.sv
mips_hazard.sv
mips_core.sv
mips_stdio.sv
wb_arbiter.sv
mips_system.sv
mips_system_chk.sv
tb_mips_system.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mips_system -f mips_system.f -o sim \
	&& ./obj_dir/sim | grep "All checks passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tb_mips_system.sv */
`timescale 1ns/1ns

module tb_mips_system;
	import mips_pkg::*;

	localparam int N_PROG       = 37;
	localparam int N_OUT        = 8;
	localparam int MEM_WORDS    = 128;
	localparam int IO_TIMEOUT   = 600;
	localparam int QUIET_CYCLES = 300;

	logic    clk;
	logic    rst_n;
	wb_m2s_t wb;
	word_t   wb_dat_i;
	logic    wb_ack_i;
	logic    io_valid;
	word_t   io_data;

	word_t prog [N_PROG];
	word_t expected [N_OUT];
	word_t mem [MEM_WORDS];

	// Slave state
	int    seed;
	logic  rand_waits;
	int    wait_cnt;
	logic  in_cycle;
	logic  first_seen;
	word_t first_adr;
	logic  first_we;
	int    wr_count;
	word_t wr_adr;
	word_t wr_dat;

	mips_system UUT (
		.clk(clk), .rst_n(rst_n), .wb(wb), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
		.io_valid(io_valid), .io_data(io_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Wishbone slave with optional wait states
	always @(posedge clk) begin
		#1;
		if (!rst_n) begin
			wb_ack_i   = 1'b0;
			in_cycle   = 1'b0;
			first_seen = 1'b0;
			wr_count   = 0;
		end else if (wb_ack_i) begin
			wb_ack_i = 1'b0;
		end else if (wb.cyc && wb.stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				wait_cnt = rand_waits ? ($random(seed) & 3) : 0;
				if (!first_seen) begin
					first_seen = 1'b1;
					first_adr  = wb.adr;
					first_we   = wb.we;
				end
			end
			if (wait_cnt == 0) begin
				wb_ack_i = 1'b1;
				in_cycle = 1'b0;
				if (wb.we) begin
					mem[wb.adr[8:2]] = wb.dat;
					wr_count++;
					wr_adr = wb.adr;
					wr_dat = wb.dat;
				end else begin
					wb_dat_i = mem[wb.adr[8:2]];
				end
			end else begin
				wait_cnt--;
			end
		end
	end

	// Bus assertions in the bound checker
	always @(negedge clk) begin
		if (UUT.arbiter.chk.err_count != 0) begin
			$display("A Wishbone protocol assertion failed");
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

	task automatic load_tables();
		// ALU chain with $1 as the output port address
		prog[0]  = 32'h3C01FC00; // lui   $1, 0xFC00
		prog[1]  = 32'h24020005; // addiu $2, $0, 5
		prog[2]  = 32'h24430007; // addiu $3, $2, 7
		prog[3]  = 32'h00622021; // addu  $4, $3, $2
		prog[4]  = 32'hAC240000; // sw    $4, 0($1)
		prog[5]  = 32'h00832823; // subu  $5, $4, $3
		prog[6]  = 32'h00A43024; // and   $6, $5, $4
		prog[7]  = 32'h00C33825; // or    $7, $6, $3
		prog[8]  = 32'h00A7402A; // slt   $8, $5, $7
		prog[9]  = 32'h00074900; // sll   $9, $7, 4
		prog[10] = 32'h01285021; // addu  $10, $9, $8
		prog[11] = 32'hAC2A0000; // sw    $10, 0($1)
		prog[12] = 32'h3C0B1234; // lui   $11, 0x1234
		prog[13] = 32'h016A5825; // or    $11, $11, $10
		prog[14] = 32'hAC2B0000; // sw    $11, 0($1)
		prog[15] = 32'h00026023; // subu  $12, $0, $2
		prog[16] = 32'h0182682A; // slt   $13, $12, $2
		prog[17] = 32'hAC2D0000; // sw    $13, 0($1)
		// RAM store, load and use
		prog[18] = 32'h240E0100; // addiu $14, $0, 0x100
		prog[19] = 32'hADCB0000; // sw    $11, 0($14)
		prog[20] = 32'h8DCF0000; // lw    $15, 0($14)
		prog[21] = 32'h25F00001; // addiu $16, $15, 1
		prog[22] = 32'hAC300000; // sw    $16, 0($1)
		// Control flow where wrong-path stores must vanish
		prog[23] = 32'h10420002; // beq   $2, $2, +2
		prog[24] = 32'hAC220000; // sw    $2, 0($1)
		prog[25] = 32'hAC230000; // sw    $3, 0($1)
		prog[26] = 32'h14420001; // bne   $2, $2, +1
		prog[27] = 32'hAC270000; // sw    $7, 0($1)
		prog[28] = 32'h0800001F; // j     31
		prog[29] = 32'hAC220000; // sw    $2, 0($1)
		prog[30] = 32'hAC230000; // sw    $3, 0($1)
		prog[31] = 32'h0C000022; // jal   34
		prog[32] = 32'hAC3F0000; // sw    $31, 0($1)
		prog[33] = 32'h08000021; // j     33
		prog[34] = 32'hAC3F0000; // sw    $31, 0($1)
		prog[35] = 32'h03E00008; // jr    $31
		prog[36] = 32'hAC220000; // sw    $2, 0($1)

		expected[0] = 32'h0000_0011;
		expected[1] = 32'h0000_00D1;
		expected[2] = 32'h1234_00D1;
		expected[3] = 32'h0000_0001;
		expected[4] = 32'h1234_00D2;
		expected[5] = 32'h0000_000D;
		// Link value of jal at 0x7C in the callee and after return
		expected[6] = 32'h0000_0080;
		expected[7] = 32'h0000_0080;
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR: %s is %h, expected %h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic wait_output(input int idx);
		int   n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < IO_TIMEOUT && !seen; n++) begin
			@(negedge clk);
			seen = io_valid;
		end
		if (!seen) begin
			$display("Timed out waiting for output number %0d on io_valid", idx);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	endtask

	task automatic expect_quiet();
		int n;
		for (n = 0; n < QUIET_CYCLES; n++) begin
			@(negedge clk);
			if (io_valid) begin
				$display("Unexpected io_valid after the last output, io_data %h", io_data);
				$display("Checks failed");
				$fatal(1, "extra output");
			end
		end
	endtask

	task automatic run_pass(input logic random_waits);
		@(posedge clk);
		#1;
		rst_n      = 1'b0;
		rand_waits = random_waits;
		@(posedge clk);
		#1;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'hBAD0_0000 ^ word_t'(i);
		for (int i = 0; i < N_PROG; i++)
			mem[i] = prog[i];
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("wb.cyc", word_t'(wb.cyc), '0);
		check_value("wb.stb", word_t'(wb.stb), '0);
		check_value("io_valid", word_t'(io_valid), '0);
		@(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int k = 0; k < N_OUT; k++) begin
			wait_output(k);
			check_value("io_data", io_data, expected[k]);
		end

		check_value("first wb.adr", first_adr, RESET_PC);
		check_value("first wb.we", word_t'(first_we), '0);
		check_value("wb write count", word_t'(wr_count), 32'd1);
		check_value("wb.adr of write", wr_adr, 32'h0000_0100);
		check_value("wb.dat of write", wr_dat, 32'h1234_00D1);
		expect_quiet();
	endtask

	initial begin
		seed       = 26737;
		rst_n      = 1'b0;
		rand_waits = 1'b0;
		wb_ack_i   = 1'b0;
		wb_dat_i   = '0;
		wait_cnt   = 0;
		in_cycle   = 1'b0;
		first_seen = 1'b0;
		first_adr  = '0;
		first_we   = 1'b0;
		wr_count   = 0;
		wr_adr     = '0;
		wr_dat     = '0;
		load_tables();

		// Zero wait states first and random ones after
		run_pass(1'b0);
		run_pass(1'b1);

		$display("All checks passed");
		$finish;
	end

endmodule

/* mips_system_chk.sv */
`timescale 1ns/1ns

module mips_system_chk (
	input logic              clk,
	input logic              rst_n,
	input mips_pkg::wb_m2s_t wb,
	input logic              wb_ack_i
);
	import mips_pkg::*;

	// Number of failed assertions
	int err_count = 0;

	// Strobe only inside a cycle
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb.stb |-> wb.cyc)
		else begin
			$error("wb stb high while cyc is low");
			err_count++;
		end

	// Request held until the slave acks with dat checked on writes only
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(wb.stb && !wb_ack_i) |=> (wb.stb && $stable(wb.adr) && $stable(wb.we)
		&& (!wb.we || $stable(wb.dat))))
		else begin
			$error("wb request changed before ack");
			err_count++;
		end

	// One idle cycle after each ack
	a_gap_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack_i |=> !wb.stb)
		else begin
			$error("wb stb high in the cycle after ack");
			err_count++;
		end

endmodule

bind wb_arbiter mips_system_chk chk (
	.clk(clk), .rst_n(rst_n), .wb(wb), .wb_ack_i(wb_ack_i)
);

/* mips_system.sv */
`timescale 1ns/1ns

module mips_system (
	input  logic              clk,
	input  logic              rst_n,
	output mips_pkg::wb_m2s_t wb,
	input  mips_pkg::word_t   wb_dat_i,
	input  logic              wb_ack_i,
	output logic              io_valid,
	output mips_pkg::word_t   io_data
);
	import mips_pkg::*;

	mem_req_t ic_req, dc_req, io_req;
	mem_rsp_t ic_rsp, dc_rsp, io_rsp;

	mips_core core (
		.clk(clk), .rst_n(rst_n),
		.ic_req(ic_req), .ic_rsp(ic_rsp),
		.dc_req(dc_req), .dc_rsp(dc_rsp),
		.io_req(io_req), .io_rsp(io_rsp)
	);

	// Output port, selected by the core from the address
	mips_stdio stdio (
		.clk(clk), .rst_n(rst_n), .req(io_req), .rsp(io_rsp),
		.io_valid(io_valid), .io_data(io_data)
	);

	wb_arbiter arbiter (
		.clk(clk), .rst_n(rst_n),
		.ic_req(ic_req), .ic_rsp(ic_rsp),
		.dc_req(dc_req), .dc_rsp(dc_rsp),
		.wb(wb), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
	);

endmodule

/* wb_arbiter.sv */
`timescale 1ns/1ns

module wb_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::mem_req_t ic_req,
	output mips_pkg::mem_rsp_t ic_rsp,
	input  mips_pkg::mem_req_t dc_req,
	output mips_pkg::mem_rsp_t dc_rsp,
	output mips_pkg::wb_m2s_t  wb,
	input  mips_pkg::word_t    wb_dat_i,
	input  logic               wb_ack_i
);
	import mips_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_INST,
		ST_DATA
	} state_t;

	state_t state;
	logic   busy, is_data;

	// Data first, transfers run to completion
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (dc_req.req)
						state <= ST_DATA;
					else if (ic_req.req)
						state <= ST_INST;
				end
				default: begin
					if (wb_ack_i)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	assign busy    = (state != ST_IDLE);
	assign is_data = (state == ST_DATA);

	// Requesters hold their fields until ack, so the bus can follow them directly
	assign wb = '{cyc: busy, stb: busy, we: is_data & dc_req.we,
		adr: is_data ? dc_req.adr : ic_req.adr, dat: dc_req.wdata};

	assign ic_rsp = '{ack: (state == ST_INST) & wb_ack_i, rdata: wb_dat_i};
	assign dc_rsp = '{ack: is_data & wb_ack_i, rdata: wb_dat_i};

endmodule

/* mips_stdio.sv */
`timescale 1ns/1ns

module mips_stdio (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::mem_req_t req,
	output mips_pkg::mem_rsp_t rsp,
	output logic               io_valid,
	output mips_pkg::word_t    io_data
);
	import mips_pkg::*;

	// Always ready, reads come back as zero
	assign rsp = '{ack: req.req, rdata: '0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			io_valid <= 1'b0;
		else
			io_valid <= req.req & req.we;
	end

	always_ff @(posedge clk) begin
		if (req.req && req.we)
			io_data <= req.wdata;
	end

endmodule

/* mips_core.sv */
`timescale 1ns/1ns

module mips_core (
	input  logic               clk,
	input  logic               rst_n,
	output mips_pkg::mem_req_t ic_req,
	input  mips_pkg::mem_rsp_t ic_rsp,
	output mips_pkg::mem_req_t dc_req,
	input  mips_pkg::mem_rsp_t dc_rsp,
	output mips_pkg::mem_req_t io_req,
	input  mips_pkg::mem_rsp_t io_rsp
);
	import mips_pkg::*;

	typedef struct packed {
		word_t instr;
		word_t pc_next;
	} if_id_t;

	typedef struct packed {
		ctrl_t      ctrl;
		word_t      pc_next;
		word_t      jtarget;
		word_t      rs_data;
		word_t      rt_data;
		word_t      imm;
		logic [4:0] shamt;
		reg_idx_t   wreg;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		logic     zero;
		word_t    br_target;
		word_t    result;
		word_t    rt_data;
		reg_idx_t wreg;
	} ex_mem_t;

	typedef struct packed {
		logic     regwrite;
		reg_idx_t wreg;
		word_t    wdata;
	} mem_wb_t;

	if_id_t   if_id;
	id_ex_t   id_ex, id_next;
	ex_mem_t  ex_mem, ex_next;
	mem_wb_t  mem_wb, wb_next;
	word_t    pc, pc_plus4, redir_pc, redir_target;
	logic     fetch_en, redir_valid, redirect, take_branch, stall, adv;
	ctrl_t    id_ctrl;
	word_t    rf_rs, rf_rt, alu_b, alu_result, ex_result, load_data, mem_wdata;
	logic     alu_zero, mem_access, mem_io, mem_ack;
	fwd_sel_t fwd_rs, fwd_rt;

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf, input word_t ex,
			input word_t mem, input word_t wb);
		case (sel)
			FWD_EX:  return ex;
			FWD_MEM: return mem;
			FWD_WB:  return wb;
			default: return rf;
		endcase
	endfunction

	////////////////////
	// Fetch
	assign pc_plus4 = pc + 32'd4;
	assign ic_req   = '{req: fetch_en, we: 1'b0, adr: pc, wdata: '0};

	////////////////////
	// Decode
	mips_decode decode (.opcode(if_id.instr[31:26]), .funct(if_id.instr[5:0]), .ctrl(id_ctrl));

	mips_regfile regfile (
		.clk(clk), .rst_n(rst_n), .rs(if_id.instr[25:21]), .rt(if_id.instr[20:16]),
		.rs_data(rf_rs), .rt_data(rf_rt),
		.we(mem_wb.regwrite), .wreg(mem_wb.wreg), .wdata(mem_wb.wdata)
	);

	mips_hazard hazard (
		.rs(if_id.instr[25:21]), .rt(if_id.instr[20:16]),
		.ex_dst(id_ex.wreg), .mem_dst(ex_mem.wreg), .wb_dst(mem_wb.wreg),
		.ex_rw(id_ex.ctrl.regwrite), .ex_load(id_ex.ctrl.memread),
		.mem_rw(ex_mem.ctrl.regwrite), .wb_rw(mem_wb.regwrite),
		.fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .stall(stall)
	);

	always_comb begin
		id_next.ctrl    = id_ctrl;
		id_next.pc_next = if_id.pc_next;
		id_next.jtarget = {if_id.pc_next[31:28], if_id.instr[25:0], 2'b00};
		id_next.rs_data = fwd_mux(fwd_rs, rf_rs, ex_result, mem_wdata, mem_wb.wdata);
		id_next.rt_data = fwd_mux(fwd_rt, rf_rt, ex_result, mem_wdata, mem_wb.wdata);
		id_next.imm     = id_ctrl.imm_zero ? {16'b0, if_id.instr[15:0]} :
			{{16{if_id.instr[15]}}, if_id.instr[15:0]};
		id_next.shamt   = if_id.instr[10:6];
		if (id_ctrl.islink)
			id_next.wreg = LINK_REG;
		else
			id_next.wreg = id_ctrl.regdst ? if_id.instr[15:11] : if_id.instr[20:16];
	end

	////////////////////
	// Execute
	assign alu_b = id_ex.ctrl.alusrc ? id_ex.imm : id_ex.rt_data;

	mips_alu alu (
		.alu_op(id_ex.ctrl.alu_op), .a(id_ex.rs_data), .b(alu_b), .shamt(id_ex.shamt),
		.result(alu_result), .zero(alu_zero)
	);

	// jal leaves its return address as the result
	assign ex_result = id_ex.ctrl.islink ? id_ex.pc_next : alu_result;
	assign ex_next   = '{ctrl: id_ex.ctrl, zero: alu_zero,
		br_target: id_ex.pc_next + {id_ex.imm[29:0], 2'b00},
		result: ex_result, rt_data: id_ex.rt_data, wreg: id_ex.wreg};

	////////////////////
	// Memory
	assign mem_access = ex_mem.ctrl.memread | ex_mem.ctrl.memwrite;
	assign mem_io     = &ex_mem.result[31 -: IO_MASK_BITS];
	assign dc_req     = '{req: mem_access & ~mem_io, we: ex_mem.ctrl.memwrite,
		adr: ex_mem.result, wdata: ex_mem.rt_data};
	assign io_req     = '{req: mem_access & mem_io, we: ex_mem.ctrl.memwrite,
		adr: ex_mem.result, wdata: ex_mem.rt_data};
	assign mem_ack    = mem_io ? io_rsp.ack : dc_rsp.ack;
	assign load_data  = mem_io ? io_rsp.rdata : dc_rsp.rdata;
	assign mem_wdata  = ex_mem.ctrl.memtoreg ? load_data : ex_mem.result;
	assign wb_next    = '{regwrite: ex_mem.ctrl.regwrite, wreg: ex_mem.wreg, wdata: mem_wdata};

	// Freeze everything until the data access finishes
	assign adv = ~mem_access | mem_ack;

	assign take_branch  = ex_mem.ctrl.isbranch & (ex_mem.zero ^ ex_mem.ctrl.branch_ne);
	assign redirect     = take_branch | (id_ex.ctrl.isjump & adv);
	assign redir_target = take_branch ? ex_mem.br_target :
		(id_ex.ctrl.jumpreg ? id_ex.rs_data : id_ex.jtarget);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_en    <= 1'b0;
			pc          <= RESET_PC;
			redir_valid <= 1'b0;
			redir_pc    <= RESET_PC;
			if_id       <= '0;
			id_ex       <= '0;
			ex_mem      <= '0;
			mem_wb      <= '0;
		end else begin
			fetch_en <= 1'b1;
			// A fetch in flight keeps its address, the new PC waits for its ack
			if (redirect) begin
				if (ic_rsp.ack) begin
					pc          <= redir_target;
					redir_valid <= 1'b0;
				end else begin
					redir_pc    <= redir_target;
					redir_valid <= 1'b1;
				end
			end else if (ic_rsp.ack && redir_valid) begin
				pc          <= redir_pc;
				redir_valid <= 1'b0;
			end else if (ic_rsp.ack && adv && !stall) begin
				pc <= pc_plus4;
			end

			if (redirect)
				if_id <= '0;
			else if (adv && !stall)
				if_id <= (ic_rsp.ack && !redir_valid) ? if_id_t'{ic_rsp.rdata, pc_plus4} : '0;

			if (redirect)
				id_ex <= '0;
			else if (adv)
				id_ex <= stall ? '0 : id_next;

			if (take_branch)
				ex_mem <= '0;
			else if (adv)
				ex_mem <= ex_next;

			mem_wb <= adv ? wb_next : '0;
		end
	end

endmodule

/* mips_hazard.sv */
`timescale 1ns/1ns

module mips_hazard (
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::reg_idx_t ex_dst,
	input  mips_pkg::reg_idx_t mem_dst,
	input  mips_pkg::reg_idx_t wb_dst,
	input  logic               ex_rw,
	input  logic               ex_load,
	input  logic               mem_rw,
	input  logic               wb_rw,
	output mips_pkg::fwd_sel_t fwd_rs,
	output mips_pkg::fwd_sel_t fwd_rt,
	output logic               stall
);
	import mips_pkg::*;

	// Youngest writer wins, a load in EX has no data yet
	function automatic fwd_sel_t pick(input reg_idx_t src);
		if (src == '0)
			return FWD_REG;
		if (ex_rw && !ex_load && ex_dst == src)
			return FWD_EX;
		if (mem_rw && mem_dst == src)
			return FWD_MEM;
		if (wb_rw && wb_dst == src)
			return FWD_WB;
		return FWD_REG;
	endfunction

	always_comb begin
		fwd_rs = pick(rs);
		fwd_rt = pick(rt);
	end

	assign stall = ex_rw && ex_load && ex_dst != '0 && (ex_dst == rs || ex_dst == rt);

endmodule

/* mips_regfile.sv */
`timescale 1ns/1ns

module mips_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	output mips_pkg::word_t    rs_data,
	output mips_pkg::word_t    rt_data,
	input  logic               we,
	input  mips_pkg::reg_idx_t wreg,
	input  mips_pkg::word_t    wdata
);
	import mips_pkg::*;

	word_t regs [32];

	// Register 0 is never written, so it reads as zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wreg != '0) begin
			regs[wreg] <= wdata;
		end
	end

	// Same-cycle write shows up on the read side
	assign rs_data = (we && wreg != '0 && wreg == rs) ? wdata : regs[rs];
	assign rt_data = (we && wreg != '0 && wreg == rt) ? wdata : regs[rt];

endmodule

/* mips_alu.sv */
`timescale 1ns/1ns

module mips_alu (
	input  mips_pkg::alu_op_t alu_op,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  logic [4:0]        shamt,
	output mips_pkg::word_t   result,
	output logic              zero
);
	import mips_pkg::*;

	always_comb begin
		case (alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLL: result = b << shamt;
			// Immediate into the upper half
			ALU_LUI: result = {b[15:0], 16'b0};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* mips_decode.sv */
`timescale 1ns/1ns

module mips_decode (
	input  logic [5:0]      opcode,
	input  logic [5:0]      funct,
	output mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst   = 1'b1;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					// jr writes nothing, target comes from rs
					FN_JR:   ctrl = '{isjump: 1'b1, jumpreg: 1'b1, default: '0};
					default: ctrl = '0;
				endcase
			end
			OP_ADDIU: ctrl = '{regwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_ADD, default: '0};
			OP_LUI: ctrl = '{regwrite: 1'b1, alusrc: 1'b1, imm_zero: 1'b1,
				alu_op: ALU_LUI, default: '0};
			OP_LW: ctrl = '{regwrite: 1'b1, memtoreg: 1'b1, memread: 1'b1, alusrc: 1'b1,
				alu_op: ALU_ADD, default: '0};
			OP_SW: ctrl = '{memwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_ADD, default: '0};
			// Branches compare through the subtractor
			OP_BEQ: ctrl = '{isbranch: 1'b1, alu_op: ALU_SUB, default: '0};
			OP_BNE: ctrl = '{isbranch: 1'b1, branch_ne: 1'b1, alu_op: ALU_SUB, default: '0};
			OP_J: ctrl = '{isjump: 1'b1, default: '0};
			OP_JAL: ctrl = '{regwrite: 1'b1, isjump: 1'b1, islink: 1'b1, default: '0};
			default: ctrl = '0;
		endcase
	end

endmodule

/* mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  fwd_sel_t;

	localparam word_t    RESET_PC     = 32'h0000_0000;
	localparam int       IO_MASK_BITS = 6;
	localparam reg_idx_t LINK_REG     = 5'd31;

	// ALU operations
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_SLT = 4'd4;
	localparam alu_op_t ALU_SLL = 4'd5;
	localparam alu_op_t ALU_LUI = 4'd6;

	// Operand sources seen by decode
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_EX  = 2'd1;
	localparam fwd_sel_t FWD_MEM = 2'd2;
	localparam fwd_sel_t FWD_WB  = 2'd3;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type funct codes
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef struct packed {
		logic    regwrite;
		logic    regdst;
		logic    memtoreg;
		logic    memread;
		logic    memwrite;
		logic    isbranch;
		logic    branch_ne;
		logic    alusrc;
		logic    isjump;
		logic    jumpreg;
		logic    islink;
		alu_op_t alu_op;
		logic    imm_zero;
	} ctrl_t;

	typedef struct packed {
		logic  req;
		logic  we;
		word_t adr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic  ack;
		word_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wb_m2s_t;

endpackage
